//--- bench/exec_pipe_model.svh
// architectural state that the pipeline has to reproduce
pipe_pkg::word_t arch_regs [32];
pipe_pkg::word_t arch_mem [2**dmem_addr_bits];
pipe_pkg::word_t pc_count;

// expected write-backs, oldest at the front
pipe_pkg::reg_idx_t exp_rd_q [$];
pipe_pkg::word_t    exp_data_q [$];
int                 exp_edge_q [$];

integer seed;

// every opcode once, picked with four random bits
pipe_pkg::opcode_t op_table [16] = '{
	pipe_pkg::add, pipe_pkg::sub, pipe_pkg::and_op, pipe_pkg::or_op,
	pipe_pkg::xor_op, pipe_pkg::slt, pipe_pkg::sll, pipe_pkg::srl,
	pipe_pkg::addi, pipe_pkg::andi, pipe_pkg::ori, pipe_pkg::xori,
	pipe_pkg::slti, pipe_pkg::lw, pipe_pkg::sw, pipe_pkg::jal
};

// same state as the DUT right after reset
task automatic clear_model();
	for (int i = 0; i < 32; i++) begin
		arch_regs[i] = '0;
	end
	for (int i = 0; i < 2**dmem_addr_bits; i++) begin
		arch_mem[i] = '0;
	end
	pc_count = 32'h0000_0100;
endtask

// mostly x0 to x3 so that hazards crowd together
function automatic pipe_pkg::reg_idx_t pick_reg();
	logic [31:0] r;
	r = $random(seed);
	if (r[7:5] == 3'd0)
		return r[4:0];
	return {3'b000, r[1:0]};
endfunction

// drives one random instruction and executes it on the model
task automatic send_random(input int issue_edge);
	logic [31:0]               r;
	logic [dmem_addr_bits-1:0] widx;
	pipe_pkg::word_t           a;
	pipe_pkg::word_t           b;
	pipe_pkg::word_t           res;
	r            = $random(seed);
	widx         = r[dmem_addr_bits+3:4];
	issue_valid  = 1'b1;
	issue_opcode = op_table[r[3:0]];
	issue_rs1    = pick_reg();
	issue_rs2    = pick_reg();
	issue_rd     = pick_reg();
	issue_imm    = $random(seed);
	issue_pc     = pc_count;
	pc_count     = pc_count + 32'd1;
	a            = arch_regs[issue_rs1];
	b            = arch_regs[issue_rs2];
	res          = '0;
	// steer rs1 plus immediate onto a word inside the data memory
	if ((issue_opcode == pipe_pkg::lw) || (issue_opcode == pipe_pkg::sw))
		issue_imm = {{(32-dmem_addr_bits){1'b0}}, widx} - a;
	case (issue_opcode)
		pipe_pkg::add:    res = a + b;
		pipe_pkg::sub:    res = a - b;
		pipe_pkg::and_op: res = a & b;
		pipe_pkg::or_op:  res = a | b;
		pipe_pkg::xor_op: res = a ^ b;
		pipe_pkg::slt:    res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
		pipe_pkg::sll:    res = a << issue_imm[4:0];
		pipe_pkg::srl:    res = a >> issue_imm[4:0];
		pipe_pkg::addi:   res = a + issue_imm;
		pipe_pkg::andi:   res = a & issue_imm;
		pipe_pkg::ori:    res = a | issue_imm;
		pipe_pkg::xori:   res = a ^ issue_imm;
		pipe_pkg::slti:   res = ($signed(a) < $signed(issue_imm)) ? 32'd1 : 32'd0;
		pipe_pkg::lw:     res = arch_mem[widx];
		pipe_pkg::sw:     arch_mem[widx] = b;
		pipe_pkg::jal:    res = issue_pc + 32'd1;
		default:          res = '0;
	endcase
	// sw and x0 destinations never reach write-back
	if ((issue_opcode != pipe_pkg::sw) && (issue_rd != '0)) begin
		arch_regs[issue_rd] = res;
		exp_rd_q.push_back(issue_rd);
		exp_data_q.push_back(res);
		exp_edge_q.push_back(issue_edge);
	end
endtask

//--- bench/exec_pipe_tb.sv
module exec_pipe_tb;

	localparam int dmem_addr_bits = 4;
	localparam int num_instr      = 2000;
	// one bubble per eight instructions on average, plus reset and drain
	localparam int max_cycles     = num_instr * 9 / 8 + 100;

	logic               clk = 1'b0;
	logic               arst_n;
	logic               issue_valid;
	pipe_pkg::opcode_t  issue_opcode;
	pipe_pkg::reg_idx_t issue_rs1;
	pipe_pkg::reg_idx_t issue_rs2;
	pipe_pkg::reg_idx_t issue_rd;
	pipe_pkg::word_t    issue_imm;
	pipe_pkg::word_t    issue_pc;
	logic               wb_valid;
	pipe_pkg::reg_idx_t wb_rd;
	pipe_pkg::word_t    wb_data;

	// rising edges seen so far
	int cycle = 0;
	int sent  = 0;

	`include "exec_pipe_model.svh"

	exec_pipe_top #(
		.dmem_addr_bits(dmem_addr_bits)
	) exec_pipe_top_i (
		.clk, .arst_n, .issue_valid, .issue_opcode, .issue_rs1, .issue_rs2, .issue_rd,
		.issue_imm, .issue_pc, .wb_valid, .wb_rd, .wb_data
	);

	always #10 clk = ~clk;

	always @(posedge clk) begin
		cycle <= cycle + 1;
		if (cycle >= max_cycles) begin
			abort_run($sformatf("timeout after %0d cycles, %0d of %0d instructions sent",
				cycle, sent, num_instr));
		end
	end

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("TB FAILED");
		$fatal(1, "%s", why);
	endtask

	task automatic check_value(input string name, input logic [31:0] actual,
		input logic [31:0] expected);
		if (actual !== expected) begin
			abort_run($sformatf("[FAIL] %s: got %h, expected %h", name, actual, expected));
		end
	endtask

	// sampled at the falling edge, where MEM/WB outputs are settled
	task automatic check_writeback();
		if (wb_valid) begin
			if (exp_rd_q.size() == 0) begin
				abort_run($sformatf("wb_valid rose for x%0d with no write-back expected",
					wb_rd));
			end else begin
				check_value("wb_rd", 32'(wb_rd), 32'(exp_rd_q.pop_front()));
				check_value("wb_data", wb_data, exp_data_q.pop_front());
				// MEM/WB is loaded two edges after the issue edge
				check_value("wb_valid delay", 32'(cycle - exp_edge_q.pop_front()), 32'd2);
			end
		end
	endtask

	initial begin
		logic [31:0] r;
		int          drain;
		seed         = 32'he132;
		arst_n       = 1'b0;
		issue_valid  = 1'b0;
		issue_opcode = '0;
		issue_rs1    = '0;
		issue_rs2    = '0;
		issue_rd     = '0;
		issue_imm    = '0;
		issue_pc     = '0;
		clear_model();
		repeat (4) @(posedge clk);
		@(negedge clk);
		arst_n = 1'b1;

		// check first, then drive, so the model never runs ahead of a pop
		while (sent < num_instr) begin
			@(negedge clk);
			check_writeback();
			r = $random(seed);
			if ((r % 9) == 0) begin
				issue_valid = 1'b0;
			end else begin
				send_random(cycle + 1);
				sent++;
			end
		end
		@(negedge clk);
		check_writeback();
		issue_valid = 1'b0;

		// the last writers need three more edges at most
		drain = 0;
		while ((exp_rd_q.size() != 0) && (drain < 10)) begin
			@(negedge clk);
			check_writeback();
			drain++;
		end
		// idle tail, nothing may write back any more
		repeat (4) begin
			@(negedge clk);
			check_writeback();
		end

		if (exp_rd_q.size() != 0) begin
			abort_run($sformatf("%0d expected write-backs never arrived", exp_rd_q.size()));
		end else begin
			$display("TB PASSED");
			$finish;
		end
	end

endmodule

//--- common/pipe_pkg.sv
package pipe_pkg;

	// one machine word, used for register and memory values
	typedef logic [31:0] word_t;

	// register file index, x0 to x31
	typedef logic [4:0] reg_idx_t;

	// already-decoded opcode as handed over by the environment
	typedef logic [6:0] opcode_t;

	// select codes for the ALU operand and store data muxes
	typedef logic [1:0] fwd_a_t;
	typedef logic [2:0] fwd_b_t;
	typedef logic [1:0] fwd_st_t;

	// register-register forms
	localparam opcode_t add    = 7'h01;
	localparam opcode_t sub    = 7'h02;
	localparam opcode_t and_op = 7'h03;
	localparam opcode_t or_op  = 7'h04;
	localparam opcode_t xor_op = 7'h05;
	localparam opcode_t slt    = 7'h06;

	// shifts take their amount from the immediate
	localparam opcode_t sll    = 7'h08;
	localparam opcode_t srl    = 7'h09;

	// immediate forms
	localparam opcode_t addi   = 7'h10;
	localparam opcode_t andi   = 7'h11;
	localparam opcode_t ori    = 7'h12;
	localparam opcode_t xori   = 7'h13;
	localparam opcode_t slti   = 7'h14;

	// memory access, address is rs1 plus immediate
	localparam opcode_t lw     = 7'h20;
	localparam opcode_t sw     = 7'h21;

	// jump and link, rd gets pc plus one
	localparam opcode_t jal    = 7'h30;

	// first operand sources
	localparam fwd_a_t fwd_a_pc     = 2'b00;
	localparam fwd_a_t fwd_a_ex_mem = 2'b01;
	localparam fwd_a_t fwd_a_mem_wb = 2'b10;
	localparam fwd_a_t fwd_a_reg    = 2'b11;

	// second operand sources
	localparam fwd_b_t fwd_b_imm    = 3'b000;
	localparam fwd_b_t fwd_b_one    = 3'b001;
	localparam fwd_b_t fwd_b_ex_mem = 3'b010;
	localparam fwd_b_t fwd_b_mem_wb = 3'b011;
	localparam fwd_b_t fwd_b_reg    = 3'b100;

	// store data sources, taken on rs2
	localparam fwd_st_t fwd_st_reg    = 2'b00;
	localparam fwd_st_t fwd_st_ex_mem = 2'b01;
	localparam fwd_st_t fwd_st_mem_wb = 2'b10;

endpackage

//--- common/stage_if.sv
interface stage_if;

	// instruction present in this stage
	logic valid;

	// instruction writes rd
	logic wr;

	// destination register
	pipe_pkg::reg_idx_t rd;

	// ALU result, or load data once past the memory stage
	pipe_pkg::word_t result;

	// rs2 value to be stored, already forwarded
	pipe_pkg::word_t store_data;

	// stage that fills the register
	modport producer (output valid, wr, rd, result, store_data);

	// next stage reading the register
	modport consumer (input valid, wr, rd, result, store_data);

	// forwarding unit only compares destinations
	modport hazard (input valid, wr, rd);

endinterface

//--- exec_pipe.f
common/pipe_pkg.sv
common/stage_if.sv
logic/register_file.sv
logic/issue_stage.sv
logic/forward_unit.sv
logic/execute_stage.sv
logic/memory_stage.sv
logic/exec_pipe_top.sv
+incdir+bench
bench/exec_pipe_tb.sv

//--- logic/exec_pipe_top.sv
module exec_pipe_top #(
	parameter int dmem_addr_bits = 4
) (
	input  logic               clk,
	input  logic               arst_n,
	input  logic               issue_valid,
	input  pipe_pkg::opcode_t  issue_opcode,
	input  pipe_pkg::reg_idx_t issue_rs1,
	input  pipe_pkg::reg_idx_t issue_rs2,
	input  pipe_pkg::reg_idx_t issue_rd,
	input  pipe_pkg::word_t    issue_imm,
	input  pipe_pkg::word_t    issue_pc,
	output logic               wb_valid,
	output pipe_pkg::reg_idx_t wb_rd,
	output pipe_pkg::word_t    wb_data
);

	// register file read and write ports
	pipe_pkg::reg_idx_t rs1_addr;
	pipe_pkg::reg_idx_t rs2_addr;
	pipe_pkg::word_t    rs1_data;
	pipe_pkg::word_t    rs2_data;
	logic               rf_we;
	pipe_pkg::reg_idx_t rf_wr_addr;
	pipe_pkg::word_t    rf_wr_data;

	// ID/EX fields
	logic               id_ex_valid;
	pipe_pkg::opcode_t  id_ex_opcode;
	pipe_pkg::reg_idx_t id_ex_rs1;
	pipe_pkg::reg_idx_t id_ex_rs2;
	pipe_pkg::reg_idx_t id_ex_rd;
	logic               id_ex_wr;
	pipe_pkg::word_t    id_ex_rs1_data;
	pipe_pkg::word_t    id_ex_rs2_data;
	pipe_pkg::word_t    id_ex_imm;
	pipe_pkg::word_t    id_ex_pc;

	// forwarding selects and values
	pipe_pkg::fwd_a_t   forward_a;
	pipe_pkg::fwd_b_t   forward_b;
	pipe_pkg::fwd_st_t  store_fwd;
	pipe_pkg::word_t    mem_fwd_data;
	logic               ex_mem_is_load;

	stage_if ex_mem ();
	stage_if mem_wb ();

	register_file register_file_i (
		.clk, .arst_n, .rs1_addr, .rs2_addr, .rs1_data, .rs2_data,
		.we(rf_we), .wr_addr(rf_wr_addr), .wr_data(rf_wr_data)
	);

	issue_stage issue_stage_i (
		.clk, .arst_n, .issue_valid, .issue_opcode, .issue_rs1, .issue_rs2, .issue_rd,
		.issue_imm, .issue_pc, .rs1_addr, .rs2_addr, .rs1_data, .rs2_data,
		.id_ex_valid, .id_ex_opcode, .id_ex_rs1, .id_ex_rs2, .id_ex_rd, .id_ex_wr,
		.id_ex_rs1_data, .id_ex_rs2_data, .id_ex_imm, .id_ex_pc
	);

	forward_unit forward_unit_i (
		.id_ex_valid, .id_ex_opcode, .id_ex_rs1, .id_ex_rs2,
		.ex_mem(ex_mem), .mem_wb(mem_wb), .forward_a, .forward_b, .store_fwd
	);

	// MEM/WB result is the distance-two forward source
	execute_stage execute_stage_i (
		.clk, .arst_n, .id_ex_valid, .id_ex_opcode, .id_ex_rd, .id_ex_wr,
		.id_ex_rs1_data, .id_ex_rs2_data, .id_ex_imm, .id_ex_pc,
		.forward_a, .forward_b, .store_fwd, .mem_fwd_data,
		.mem_wb_result(mem_wb.result), .ex_mem(ex_mem), .ex_mem_is_load
	);

	memory_stage #(
		.dmem_addr_bits(dmem_addr_bits)
	) memory_stage_i (
		.clk, .arst_n, .ex_mem(ex_mem), .ex_mem_is_load, .mem_fwd_data, .mem_wb(mem_wb),
		.we(rf_we), .wr_addr(rf_wr_addr), .wr_data(rf_wr_data), .wb_valid, .wb_rd, .wb_data
	);

endmodule

//--- logic/execute_stage.sv
module execute_stage (
	input  logic               clk,
	input  logic               arst_n,
	input  logic               id_ex_valid,
	input  pipe_pkg::opcode_t  id_ex_opcode,
	input  pipe_pkg::reg_idx_t id_ex_rd,
	input  logic               id_ex_wr,
	input  pipe_pkg::word_t    id_ex_rs1_data,
	input  pipe_pkg::word_t    id_ex_rs2_data,
	input  pipe_pkg::word_t    id_ex_imm,
	input  pipe_pkg::word_t    id_ex_pc,
	input  pipe_pkg::fwd_a_t   forward_a,
	input  pipe_pkg::fwd_b_t   forward_b,
	input  pipe_pkg::fwd_st_t  store_fwd,
	input  pipe_pkg::word_t    mem_fwd_data,
	input  pipe_pkg::word_t    mem_wb_result,
	stage_if.producer          ex_mem,
	output logic               ex_mem_is_load
);

	pipe_pkg::word_t op_a;
	pipe_pkg::word_t op_b;
	pipe_pkg::word_t store_val;
	pipe_pkg::word_t alu_out;

	// operand a mux, EX/MEM value already has load data folded in
	always_comb begin
		case (forward_a)
			pipe_pkg::fwd_a_pc:     op_a = id_ex_pc;
			pipe_pkg::fwd_a_ex_mem: op_a = mem_fwd_data;
			pipe_pkg::fwd_a_mem_wb: op_a = mem_wb_result;
			default:                op_a = id_ex_rs1_data;
		endcase
	end

	// operand b mux
	always_comb begin
		case (forward_b)
			pipe_pkg::fwd_b_imm:    op_b = id_ex_imm;
			pipe_pkg::fwd_b_one:    op_b = 32'd1;
			pipe_pkg::fwd_b_ex_mem: op_b = mem_fwd_data;
			pipe_pkg::fwd_b_mem_wb: op_b = mem_wb_result;
			pipe_pkg::fwd_b_reg:    op_b = id_ex_rs2_data;
			default:                op_b = '0;
		endcase
	end

	// store data gets the same forwarding as rs2
	always_comb begin
		case (store_fwd)
			pipe_pkg::fwd_st_ex_mem: store_val = mem_fwd_data;
			pipe_pkg::fwd_st_mem_wb: store_val = mem_wb_result;
			default:                 store_val = id_ex_rs2_data;
		endcase
	end

	always_comb begin
		case (id_ex_opcode)
			// address calc and pc plus one reuse the adder
			pipe_pkg::add, pipe_pkg::addi, pipe_pkg::lw, pipe_pkg::sw, pipe_pkg::jal:
				alu_out = op_a + op_b;
			pipe_pkg::sub:                  alu_out = op_a - op_b;
			pipe_pkg::and_op, pipe_pkg::andi: alu_out = op_a & op_b;
			pipe_pkg::or_op, pipe_pkg::ori:   alu_out = op_a | op_b;
			pipe_pkg::xor_op, pipe_pkg::xori: alu_out = op_a ^ op_b;
			pipe_pkg::slt, pipe_pkg::slti:
				alu_out = ($signed(op_a) < $signed(op_b)) ? 32'd1 : 32'd0;
			// shift amount is the low five bits of the immediate
			pipe_pkg::sll:                  alu_out = op_a << op_b[4:0];
			pipe_pkg::srl:                  alu_out = op_a >> op_b[4:0];
			default:                        alu_out = '0;
		endcase
	end

	// EX/MEM control
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			ex_mem.valid   <= 1'b0;
			ex_mem.wr      <= 1'b0;
			ex_mem_is_load <= 1'b0;
		end else begin
			ex_mem.valid   <= id_ex_valid;
			ex_mem.wr      <= id_ex_valid && id_ex_wr;
			ex_mem_is_load <= id_ex_valid && (id_ex_opcode == pipe_pkg::lw);
		end
	end

	// EX/MEM payload
	always_ff @(posedge clk) begin
		ex_mem.rd         <= id_ex_rd;
		ex_mem.result     <= alu_out;
		ex_mem.store_data <= store_val;
	end

endmodule

//--- logic/forward_unit.sv
module forward_unit (
	input  logic               id_ex_valid,
	input  pipe_pkg::opcode_t  id_ex_opcode,
	input  pipe_pkg::reg_idx_t id_ex_rs1,
	input  pipe_pkg::reg_idx_t id_ex_rs2,
	stage_if.hazard            ex_mem,
	stage_if.hazard            mem_wb,
	output pipe_pkg::fwd_a_t   forward_a,
	output pipe_pkg::fwd_b_t   forward_b,
	output pipe_pkg::fwd_st_t  store_fwd
);

	logic ex_hit_rs1;
	logic ex_hit_rs2;
	logic wb_hit_rs1;
	logic wb_hit_rs2;
	logic imm_form;

	// a stage only counts when it holds a real instruction writing a nonzero rd
	assign ex_hit_rs1 = ex_mem.valid && ex_mem.wr && (ex_mem.rd != '0) && (ex_mem.rd == id_ex_rs1);
	assign ex_hit_rs2 = ex_mem.valid && ex_mem.wr && (ex_mem.rd != '0) && (ex_mem.rd == id_ex_rs2);
	assign wb_hit_rs1 = mem_wb.valid && mem_wb.wr && (mem_wb.rd != '0) && (mem_wb.rd == id_ex_rs1);
	assign wb_hit_rs2 = mem_wb.valid && mem_wb.wr && (mem_wb.rd != '0) && (mem_wb.rd == id_ex_rs2);

	// immediate forms, shifts and memory ops all take the immediate as operand b
	assign imm_form = (id_ex_opcode == pipe_pkg::addi) || (id_ex_opcode == pipe_pkg::andi) ||
	                  (id_ex_opcode == pipe_pkg::ori)  || (id_ex_opcode == pipe_pkg::xori) ||
	                  (id_ex_opcode == pipe_pkg::slti) || (id_ex_opcode == pipe_pkg::sll)  ||
	                  (id_ex_opcode == pipe_pkg::srl)  || (id_ex_opcode == pipe_pkg::lw)   ||
	                  (id_ex_opcode == pipe_pkg::sw);

	always_comb begin
		// operand a, jal adds to its own pc
		if (id_ex_opcode == pipe_pkg::jal)
			forward_a = pipe_pkg::fwd_a_pc;
		else if (ex_hit_rs1)
			forward_a = pipe_pkg::fwd_a_ex_mem;
		else if (wb_hit_rs1)
			forward_a = pipe_pkg::fwd_a_mem_wb;
		else
			forward_a = pipe_pkg::fwd_a_reg;

		// operand b, fixed sources first
		if (imm_form)
			forward_b = pipe_pkg::fwd_b_imm;
		else if (id_ex_opcode == pipe_pkg::jal)
			forward_b = pipe_pkg::fwd_b_one;
		else if (ex_hit_rs2)
			forward_b = pipe_pkg::fwd_b_ex_mem;
		else if (wb_hit_rs2)
			forward_b = pipe_pkg::fwd_b_mem_wb;
		else
			forward_b = pipe_pkg::fwd_b_reg;

		// store data follows rs2 regardless of opcode
		if (ex_hit_rs2)
			store_fwd = pipe_pkg::fwd_st_ex_mem;
		else if (wb_hit_rs2)
			store_fwd = pipe_pkg::fwd_st_mem_wb;
		else
			store_fwd = pipe_pkg::fwd_st_reg;
	end

endmodule

//--- logic/issue_stage.sv
module issue_stage (
	input  logic               clk,
	input  logic               arst_n,
	input  logic               issue_valid,
	input  pipe_pkg::opcode_t  issue_opcode,
	input  pipe_pkg::reg_idx_t issue_rs1,
	input  pipe_pkg::reg_idx_t issue_rs2,
	input  pipe_pkg::reg_idx_t issue_rd,
	input  pipe_pkg::word_t    issue_imm,
	input  pipe_pkg::word_t    issue_pc,
	output pipe_pkg::reg_idx_t rs1_addr,
	output pipe_pkg::reg_idx_t rs2_addr,
	input  pipe_pkg::word_t    rs1_data,
	input  pipe_pkg::word_t    rs2_data,
	output logic               id_ex_valid,
	output pipe_pkg::opcode_t  id_ex_opcode,
	output pipe_pkg::reg_idx_t id_ex_rs1,
	output pipe_pkg::reg_idx_t id_ex_rs2,
	output pipe_pkg::reg_idx_t id_ex_rd,
	output logic               id_ex_wr,
	output pipe_pkg::word_t    id_ex_rs1_data,
	output pipe_pkg::word_t    id_ex_rs2_data,
	output pipe_pkg::word_t    id_ex_imm,
	output pipe_pkg::word_t    id_ex_pc
);

	logic writes_rd;

	// register file is read straight from the issued indices
	assign rs1_addr = issue_rs1;
	assign rs2_addr = issue_rs2;

	// sw is the only opcode without a destination
	assign writes_rd = (issue_opcode != pipe_pkg::sw);

	// control half of ID/EX
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			id_ex_valid <= 1'b0;
			id_ex_wr    <= 1'b0;
		end else begin
			id_ex_valid <= issue_valid;
			id_ex_wr    <= issue_valid && writes_rd;
		end
	end

	// payload half, bubbles carry junk that valid masks off
	always_ff @(posedge clk) begin
		id_ex_opcode   <= issue_opcode;
		id_ex_rs1      <= issue_rs1;
		id_ex_rs2      <= issue_rs2;
		id_ex_rd       <= issue_rd;
		id_ex_rs1_data <= rs1_data;
		id_ex_rs2_data <= rs2_data;
		id_ex_imm      <= issue_imm;
		id_ex_pc       <= issue_pc;
	end

endmodule

//--- logic/memory_stage.sv
module memory_stage #(
	parameter int dmem_addr_bits = 4
) (
	input  logic               clk,
	input  logic               arst_n,
	stage_if.consumer          ex_mem,
	input  logic               ex_mem_is_load,
	output pipe_pkg::word_t    mem_fwd_data,
	stage_if.producer          mem_wb,
	output logic               we,
	output pipe_pkg::reg_idx_t wr_addr,
	output pipe_pkg::word_t    wr_data,
	output logic               wb_valid,
	output pipe_pkg::reg_idx_t wb_rd,
	output pipe_pkg::word_t    wb_data
);

	// word addressed data memory
	pipe_pkg::word_t dmem [2**dmem_addr_bits];

	logic [dmem_addr_bits-1:0] dmem_addr;
	logic                      is_store;

	assign dmem_addr = ex_mem.result[dmem_addr_bits-1:0];

	// only sw leaves wr clear on a valid instruction
	assign is_store = ex_mem.valid && !ex_mem.wr;

	// store lands at the edge that ends the MEM cycle
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			for (int i = 0; i < 2**dmem_addr_bits; i++) begin
				dmem[i] <= '0;
			end
		end else if (is_store) begin
			dmem[dmem_addr] <= ex_mem.store_data;
		end
	end

	// combinational read, so a load forwards from EX/MEM with no stall
	assign mem_fwd_data = ex_mem_is_load ? dmem[dmem_addr] : ex_mem.result;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			mem_wb.valid <= 1'b0;
			mem_wb.wr    <= 1'b0;
			wb_valid     <= 1'b0;
		end else begin
			mem_wb.valid <= ex_mem.valid;
			mem_wb.wr    <= ex_mem.wr;
			// writes to x0 never leave the pipeline
			wb_valid     <= ex_mem.valid && ex_mem.wr && (ex_mem.rd != '0);
		end
	end

	// MEM/WB payload
	always_ff @(posedge clk) begin
		mem_wb.rd         <= ex_mem.rd;
		mem_wb.result     <= mem_fwd_data;
		mem_wb.store_data <= ex_mem.store_data;
	end

	assign wb_rd   = mem_wb.rd;
	assign wb_data = mem_wb.result;

	// register file port mirrors the write-back port
	assign we      = wb_valid;
	assign wr_addr = wb_rd;
	assign wr_data = wb_data;

	a_addr_in_range: assert property (
		@(posedge clk) disable iff (!arst_n)
		(ex_mem_is_load || is_store) |-> ((ex_mem.result >> dmem_addr_bits) == '0)
	) else $error("data memory address out of range");

endmodule

//--- logic/register_file.sv
module register_file (
	input  logic               clk,
	input  logic               arst_n,
	input  pipe_pkg::reg_idx_t rs1_addr,
	input  pipe_pkg::reg_idx_t rs2_addr,
	output pipe_pkg::word_t    rs1_data,
	output pipe_pkg::word_t    rs2_data,
	input  logic               we,
	input  pipe_pkg::reg_idx_t wr_addr,
	input  pipe_pkg::word_t    wr_data
);

	// entry 0 exists but is never written and never read
	pipe_pkg::word_t regs [32];

	logic hit_rs1;
	logic hit_rs2;

	// register file starts from all zeros
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			for (int i = 0; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else if (we && (wr_addr != '0)) begin
			regs[wr_addr] <= wr_data;
		end
	end

	// write-through, an instruction issued in the write cycle sees the new value
	assign hit_rs1 = we && (wr_addr != '0) && (wr_addr == rs1_addr);
	assign hit_rs2 = we && (wr_addr != '0) && (wr_addr == rs2_addr);

	// x0 reads zero whatever the array holds
	assign rs1_data = (rs1_addr == '0) ? '0 :
	                  hit_rs1          ? wr_data : regs[rs1_addr];
	assign rs2_data = (rs2_addr == '0) ? '0 :
	                  hit_rs2          ? wr_data : regs[rs2_addr];

	// the memory stage drops writes to x0 before they get here
	a_no_x0_write: assert property (
		@(posedge clk) disable iff (!arst_n)
		we |-> (wr_addr != '0)
	) else $error("register file write to x0");

endmodule

//--- run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module exec_pipe_tb -f exec_pipe.f \
	-o exec_pipe_sim || { echo "build failed"; exit 1; }
out=$(./obj_dir/exec_pipe_sim 2>&1)
echo "$out"
echo "$out" | grep -q "TB PASSED" && echo "simulation passed" || {
	echo "simulation failed"
	exit 1
}
